// ==== ooo_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// widths, sizes, opcodes, internal op codes
// and the instruction word union
// ~~~~~~~~~~~~~~~~~~~~
package ooo_pkg;

  // datapath and index widths
  localparam int XLEN     = 32;
  localparam int REG_ID_W = 5;
  localparam int ROB_SIZE = 8;
  localparam int ROB_ID_W = 3;
  localparam int RS_SIZE  = 4;
  localparam int OP_W     = 4;

  // major opcodes, only register and immediate alu forms
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 values
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_SLL = 3'b001;
  localparam logic [2:0] FUNCT3_SLT = 3'b010;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_SRL = 3'b101;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;
  // funct7 that turns add into sub
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // internal op codes, shared by R and I forms
  localparam logic [OP_W-1:0] OP_ADD = 4'd0;
  localparam logic [OP_W-1:0] OP_SUB = 4'd1;
  localparam logic [OP_W-1:0] OP_AND = 4'd2;
  localparam logic [OP_W-1:0] OP_OR  = 4'd3;
  localparam logic [OP_W-1:0] OP_XOR = 4'd4;
  localparam logic [OP_W-1:0] OP_SLT = 4'd5;
  localparam logic [OP_W-1:0] OP_SLL = 4'd6;
  localparam logic [OP_W-1:0] OP_SRL = 4'd7;

  // one word, two decodings
  typedef union packed {
    struct packed {
      logic [6:0]          funct7;
      logic [REG_ID_W-1:0] rs2;
      logic [REG_ID_W-1:0] rs1;
      logic [2:0]          funct3;
      logic [REG_ID_W-1:0] rd;
      logic [6:0]          opcode;
    } r;
    struct packed {
      logic [11:0]         imm12;
      logic [REG_ID_W-1:0] rs1;
      logic [2:0]          funct3;
      logic [REG_ID_W-1:0] rd;
      logic [6:0]          opcode;
    } i;
  } inst_u;

endpackage

// ==== core_ifs.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// dispatch and commit interfaces
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

// issue to reservation station, one-cycle strobe
interface dispatch_if;
  import ooo_pkg::*;

  logic                valid;
  logic [OP_W-1:0]     op;
  logic [XLEN-1:0]     vj;
  logic [ROB_ID_W-1:0] qj;
  // rj/rk high: value present, else wait on q tag
  logic                rj;
  logic [XLEN-1:0]     vk;
  logic [ROB_ID_W-1:0] qk;
  logic                rk;
  logic [ROB_ID_W-1:0] robid;

  modport src (output valid, op, vj, qj, rj, vk, qk, rk, robid);
  modport dst (input valid, op, vj, qj, rj, vk, qk, rk, robid);
endinterface

// rob retire toward the register file
interface commit_if;
  import ooo_pkg::*;

  logic                valid;
  logic [REG_ID_W-1:0] rd;
  logic [XLEN-1:0]     value;
  logic [ROB_ID_W-1:0] robid;

  modport src (output valid, rd, value, robid);
  modport dst (input valid, rd, value, robid);
endinterface

// ==== alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// integer alu onto the result bus
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu (
  input  logic                            valid,
  input  logic [ooo_pkg::OP_W-1:0]        op,
  input  logic [ooo_pkg::XLEN-1:0]        a,
  input  logic [ooo_pkg::XLEN-1:0]        b,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    robid,
  output logic                            cdb_valid,
  output logic [ooo_pkg::ROB_ID_W-1:0]    cdb_robid,
  output logic [ooo_pkg::XLEN-1:0]        cdb_value
);
  import ooo_pkg::*;

  assign cdb_valid = valid;
  assign cdb_robid = robid;

  always_comb begin
    case (op)
      OP_ADD:  cdb_value = a + b;
      OP_SUB:  cdb_value = a - b;
      OP_AND:  cdb_value = a & b;
      OP_OR:   cdb_value = a | b;
      OP_XOR:  cdb_value = a ^ b;
      // signed compare, 0 or 1
      OP_SLT:  cdb_value = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      // shift amount from b[4:0]
      OP_SLL:  cdb_value = a << b[4:0];
      OP_SRL:  cdb_value = a >> b[4:0];
      default: cdb_value = '0;
    endcase
  end

endmodule

// ==== reg_file.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// register file with busy flags and tags
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk_in,
  input  logic                            rst_n,
  input  logic                            rdy_in,
  input  logic [ooo_pkg::REG_ID_W-1:0]    rs1,
  input  logic [ooo_pkg::REG_ID_W-1:0]    rs2,
  input  logic                            rename_valid,
  input  logic [ooo_pkg::REG_ID_W-1:0]    rename_rd,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    rename_robid,
  output logic [ooo_pkg::XLEN-1:0]        vj,
  output logic [ooo_pkg::XLEN-1:0]        vk,
  output logic                            busy_j,
  output logic                            busy_k,
  output logic [ooo_pkg::ROB_ID_W-1:0]    qj,
  output logic [ooo_pkg::ROB_ID_W-1:0]    qk,
  commit_if.dst                           commit
);
  import ooo_pkg::*;

  localparam int NUM_REGS = 1 << REG_ID_W;

  logic [XLEN-1:0]     regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy;
  // rob id of the newest pending writer
  logic [ROB_ID_W-1:0] tag  [NUM_REGS];

  // operand reads
  assign vj     = regs[rs1];
  assign vk     = regs[rs2];
  assign busy_j = busy[rs1];
  assign busy_k = busy[rs2];
  assign qj     = tag[rs1];
  assign qk     = tag[rs2];

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
        tag[i]  <= '0;
      end
    end else if (rdy_in) begin
      if (commit.valid && commit.rd != '0) begin
        // in-order retire, value always architectural
        regs[commit.rd] <= commit.value;
        // only the last writer frees the register
        if (tag[commit.rd] == commit.robid)
          busy[commit.rd] <= 1'b0;
      end
      // same-cycle rename overrides the clear above
      if (rename_valid && rename_rd != '0) begin
        busy[rename_rd] <= 1'b1;
        tag[rename_rd]  <= rename_robid;
      end
    end
  end

endmodule

// ==== reorder_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// reorder buffer, in-order retire
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                            clk_in,
  input  logic                            rst_n,
  input  logic                            rdy_in,
  input  logic                            alloc,
  input  logic [ooo_pkg::REG_ID_W-1:0]    alloc_rd,
  input  logic                            cdb_valid,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    cdb_robid,
  input  logic [ooo_pkg::XLEN-1:0]        cdb_value,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    query_j,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    query_k,
  output logic [ooo_pkg::ROB_ID_W-1:0]    next_robid,
  output logic                            rob_next_full,
  output logic                            rs1_ready,
  output logic                            rs2_ready,
  output logic [ooo_pkg::XLEN-1:0]        rs1_value,
  output logic [ooo_pkg::XLEN-1:0]        rs2_value,
  commit_if.src                           commit
);
  import ooo_pkg::*;

  logic [REG_ID_W-1:0] rd_q  [ROB_SIZE];
  logic [XLEN-1:0]     val_q [ROB_SIZE];
  logic [ROB_SIZE-1:0] done_q;
  // pointers wrap on their own width
  logic [ROB_ID_W-1:0] head;
  logic [ROB_ID_W-1:0] tail;
  logic [ROB_ID_W:0]   count;
  logic                retire;
  logic                commit_q;

  assign retire        = (count != '0) && done_q[head];
  assign next_robid    = tail;
  // one slot kept spare for the in-flight accept
  assign rob_next_full = (count >= ROB_SIZE - 1);

  // operand lookup for issue
  assign rs1_ready = done_q[query_j];
  assign rs1_value = val_q[query_j];
  assign rs2_ready = done_q[query_k];
  assign rs2_value = val_q[query_k];

  // held strobe is hidden during a pause
  assign commit.valid = commit_q && rdy_in;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      done_q   <= '0;
      commit_q <= 1'b0;
    end else if (rdy_in) begin
      commit_q <= retire;
      if (retire)
        head <= head + 1'b1;
      if (alloc) begin
        tail         <= tail + 1'b1;
        done_q[tail] <= 1'b0;
      end
      // bus never targets a free slot
      if (cdb_valid)
        done_q[cdb_robid] <= 1'b1;
      count <= count + alloc - retire;
    end
  end

  // entry payload and commit data
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (alloc)
        rd_q[tail] <= alloc_rd;
      if (cdb_valid)
        val_q[cdb_robid] <= cdb_value;
      if (retire) begin
        commit.rd    <= rd_q[head];
        commit.value <= val_q[head];
        commit.robid <= head;
      end
    end
  end

endmodule

// ==== reservation_station.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// reservation station, bus wake-up, alu issue
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module reservation_station (
  input  logic                            clk_in,
  input  logic                            rst_n,
  input  logic                            rdy_in,
  input  logic                            cdb_valid,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    cdb_robid,
  input  logic [ooo_pkg::XLEN-1:0]        cdb_value,
  output logic                            alu_valid,
  output logic [ooo_pkg::OP_W-1:0]        alu_op,
  output logic [ooo_pkg::XLEN-1:0]        alu_a,
  output logic [ooo_pkg::XLEN-1:0]        alu_b,
  output logic [ooo_pkg::ROB_ID_W-1:0]    alu_robid,
  output logic                            rs_next_full,
  dispatch_if.dst                         dispatch
);
  import ooo_pkg::*;

  logic [RS_SIZE-1:0]         busy;
  logic [OP_W-1:0]            op_q    [RS_SIZE];
  logic [XLEN-1:0]            vj_q    [RS_SIZE];
  logic [XLEN-1:0]            vk_q    [RS_SIZE];
  logic [ROB_ID_W-1:0]        qj_q    [RS_SIZE];
  logic [ROB_ID_W-1:0]        qk_q    [RS_SIZE];
  logic [ROB_ID_W-1:0]        robid_q [RS_SIZE];
  logic [RS_SIZE-1:0]         rj_q;
  logic [RS_SIZE-1:0]         rk_q;
  logic [$clog2(RS_SIZE)-1:0] free_idx;
  logic [$clog2(RS_SIZE)-1:0] pick_idx;
  logic                       free_found;
  logic                       pick_found;
  logic [$clog2(RS_SIZE):0]   used;

  // lowest free slot, lowest ready slot, occupancy
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    pick_found = 1'b0;
    pick_idx   = '0;
    used       = '0;
    // downward scan so the lowest index is kept
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_found = 1'b1;
        free_idx   = i[$clog2(RS_SIZE)-1:0];
      end
      if (busy[i] && rj_q[i] && rk_q[i]) begin
        pick_found = 1'b1;
        pick_idx   = i[$clog2(RS_SIZE)-1:0];
      end
      used = used + busy[i];
    end
  end

  assign rs_next_full = (used >= RS_SIZE - 1);

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= '0;
      alu_valid <= 1'b0;
    end else if (rdy_in) begin
      alu_valid <= pick_found;
      if (pick_found)
        busy[pick_idx] <= 1'b0;
      // free and picked slots are never the same
      if (dispatch.valid && free_found)
        busy[free_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      // wake-up from the bus
      for (int i = 0; i < RS_SIZE; i++) begin
        if (busy[i] && !rj_q[i] && cdb_valid && qj_q[i] == cdb_robid) begin
          vj_q[i] <= cdb_value;
          rj_q[i] <= 1'b1;
        end
        if (busy[i] && !rk_q[i] && cdb_valid && qk_q[i] == cdb_robid) begin
          vk_q[i] <= cdb_value;
          rk_q[i] <= 1'b1;
        end
      end
      if (dispatch.valid && free_found) begin
        op_q[free_idx]    <= dispatch.op;
        vj_q[free_idx]    <= dispatch.vj;
        qj_q[free_idx]    <= dispatch.qj;
        rj_q[free_idx]    <= dispatch.rj;
        vk_q[free_idx]    <= dispatch.vk;
        qk_q[free_idx]    <= dispatch.qk;
        rk_q[free_idx]    <= dispatch.rk;
        robid_q[free_idx] <= dispatch.robid;
      end
      // registered alu issue
      if (pick_found) begin
        alu_op    <= op_q[pick_idx];
        alu_a     <= vj_q[pick_idx];
        alu_b     <= vk_q[pick_idx];
        alu_robid <= robid_q[pick_idx];
      end
    end
  end

endmodule

// ==== issue_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// issue: decode, rob id, operand resolve
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issue_unit (
  input  logic                            inst_valid,
  input  ooo_pkg::inst_u                  inst,
  input  logic                            rdy_in,
  input  logic [ooo_pkg::XLEN-1:0]        rf_vj,
  input  logic [ooo_pkg::XLEN-1:0]        rf_vk,
  input  logic                            rf_busy_j,
  input  logic                            rf_busy_k,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    rf_qj,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    rf_qk,
  input  logic                            rob_rs1_ready,
  input  logic                            rob_rs2_ready,
  input  logic [ooo_pkg::XLEN-1:0]        rob_rs1_value,
  input  logic [ooo_pkg::XLEN-1:0]        rob_rs2_value,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    next_robid,
  input  logic                            cdb_valid,
  input  logic [ooo_pkg::ROB_ID_W-1:0]    cdb_robid,
  input  logic [ooo_pkg::XLEN-1:0]        cdb_value,
  input  logic                            stall,
  output logic [ooo_pkg::REG_ID_W-1:0]    rs1,
  output logic [ooo_pkg::REG_ID_W-1:0]    rs2,
  output logic [ooo_pkg::REG_ID_W-1:0]    rename_rd,
  output logic                            rename_valid,
  output logic                            rob_alloc,
  output logic [ooo_pkg::ROB_ID_W-1:0]    query_j,
  output logic [ooo_pkg::ROB_ID_W-1:0]    query_k,
  dispatch_if.src                         dispatch
);
  import ooo_pkg::*;

  logic            accept;
  logic            is_r;
  logic [XLEN-1:0] imm;
  logic [OP_W-1:0] op;
  // {ready, value} per operand
  logic [XLEN:0]   opnd_j;
  logic [XLEN:0]   opnd_k;

  // priority: free register, done rob entry, bus this cycle, else tag
  function automatic logic [XLEN:0] resolve(
    input logic                busy,
    input logic [XLEN-1:0]     rf_v,
    input logic [ROB_ID_W-1:0] tag,
    input logic                rob_rdy,
    input logic [XLEN-1:0]     rob_v,
    input logic                bus_valid,
    input logic [ROB_ID_W-1:0] bus_robid,
    input logic [XLEN-1:0]     bus_value
  );
    if (!busy) return {1'b1, rf_v};
    if (rob_rdy) return {1'b1, rob_v};
    if (bus_valid && bus_robid == tag) return {1'b1, bus_value};
    return {1'b0, rf_v};
  endfunction

  assign accept = inst_valid && !stall && rdy_in;
  assign is_r   = (inst.r.opcode == OPC_OP);
  // sign-extended I immediate
  assign imm    = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};

  // rs2 field is immediate bits in I form
  assign rs1 = inst.i.rs1;
  assign rs2 = is_r ? inst.r.rs2 : '0;

  always_comb begin
    case (inst.r.funct3)
      FUNCT3_ADD: op = (is_r && inst.r.funct7 == FUNCT7_ALT) ? OP_SUB : OP_ADD;
      FUNCT3_SLL: op = OP_SLL;
      FUNCT3_SLT: op = OP_SLT;
      FUNCT3_XOR: op = OP_XOR;
      FUNCT3_SRL: op = OP_SRL;
      FUNCT3_OR:  op = OP_OR;
      FUNCT3_AND: op = OP_AND;
      default:    op = OP_ADD;
    endcase
  end

  assign opnd_j = resolve(rf_busy_j, rf_vj, rf_qj, rob_rs1_ready, rob_rs1_value,
                          cdb_valid, cdb_robid, cdb_value);
  assign opnd_k = resolve(rf_busy_k, rf_vk, rf_qk, rob_rs2_ready, rob_rs2_value,
                          cdb_valid, cdb_robid, cdb_value);

  // rob lookup by rename tag
  assign query_j = rf_qj;
  assign query_k = rf_qk;

  assign rob_alloc    = accept;
  assign rename_rd    = inst.r.rd;
  // x0 never renamed
  assign rename_valid = accept && (inst.r.rd != '0);

  assign dispatch.valid = accept;
  assign dispatch.op    = op;
  assign dispatch.vj    = opnd_j[XLEN-1:0];
  assign dispatch.rj    = opnd_j[XLEN];
  assign dispatch.qj    = rf_qj;
  // immediate always ready as second operand
  assign dispatch.vk    = is_r ? opnd_k[XLEN-1:0] : imm;
  assign dispatch.rk    = is_r ? opnd_k[XLEN] : 1'b1;
  assign dispatch.qk    = rf_qk;
  assign dispatch.robid = next_robid;

endmodule

// ==== ooo_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// out-of-order core top level
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ooo_core (
  input  logic                            clk_in,
  input  logic                            rst_n,
  // pauses the whole core when low
  input  logic                            rdy_in,
  input  logic                            inst_valid,
  input  logic [ooo_pkg::XLEN-1:0]        inst,
  output logic                            inst_stall,
  output logic                            commit_valid,
  output logic [ooo_pkg::REG_ID_W-1:0]    commit_rd,
  output logic [ooo_pkg::XLEN-1:0]        commit_value
);
  import ooo_pkg::*;

  logic [REG_ID_W-1:0] rs1;
  logic [REG_ID_W-1:0] rs2;
  logic [REG_ID_W-1:0] rename_rd;
  logic                rename_valid;
  logic                rob_alloc;
  logic [ROB_ID_W-1:0] query_j;
  logic [ROB_ID_W-1:0] query_k;
  logic [XLEN-1:0]     rf_vj;
  logic [XLEN-1:0]     rf_vk;
  logic                rf_busy_j;
  logic                rf_busy_k;
  logic [ROB_ID_W-1:0] rf_qj;
  logic [ROB_ID_W-1:0] rf_qk;
  logic                rob_rs1_ready;
  logic                rob_rs2_ready;
  logic [XLEN-1:0]     rob_rs1_value;
  logic [XLEN-1:0]     rob_rs2_value;
  logic [ROB_ID_W-1:0] next_robid;
  logic                rob_next_full;
  logic                rs_next_full;
  // result bus
  logic                cdb_valid;
  logic [ROB_ID_W-1:0] cdb_robid;
  logic [XLEN-1:0]     cdb_value;
  // rs to alu
  logic                alu_valid;
  logic [OP_W-1:0]     alu_op;
  logic [XLEN-1:0]     alu_a;
  logic [XLEN-1:0]     alu_b;
  logic [ROB_ID_W-1:0] alu_robid;

  dispatch_if disp ();
  commit_if   cmt ();

  assign inst_stall   = rob_next_full | rs_next_full;
  assign commit_valid = cmt.valid;
  assign commit_rd    = cmt.rd;
  assign commit_value = cmt.value;

  issue_unit u_issue_unit (
    .inst_valid    (inst_valid),
    .inst          (inst),
    .rdy_in        (rdy_in),
    .rf_vj         (rf_vj),
    .rf_vk         (rf_vk),
    .rf_busy_j     (rf_busy_j),
    .rf_busy_k     (rf_busy_k),
    .rf_qj         (rf_qj),
    .rf_qk         (rf_qk),
    .rob_rs1_ready (rob_rs1_ready),
    .rob_rs2_ready (rob_rs2_ready),
    .rob_rs1_value (rob_rs1_value),
    .rob_rs2_value (rob_rs2_value),
    .next_robid    (next_robid),
    .cdb_valid     (cdb_valid),
    .cdb_robid     (cdb_robid),
    .cdb_value     (cdb_value),
    .stall         (inst_stall),
    .rs1           (rs1),
    .rs2           (rs2),
    .rename_rd     (rename_rd),
    .rename_valid  (rename_valid),
    .rob_alloc     (rob_alloc),
    .query_j       (query_j),
    .query_k       (query_k),
    .dispatch      (disp.src)
  );

  // rename tag is the allocated rob id
  reg_file u_reg_file (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .rdy_in       (rdy_in),
    .rs1          (rs1),
    .rs2          (rs2),
    .rename_valid (rename_valid),
    .rename_rd    (rename_rd),
    .rename_robid (next_robid),
    .vj           (rf_vj),
    .vk           (rf_vk),
    .busy_j       (rf_busy_j),
    .busy_k       (rf_busy_k),
    .qj           (rf_qj),
    .qk           (rf_qk),
    .commit       (cmt.dst)
  );

  reorder_buffer u_reorder_buffer (
    .clk_in        (clk_in),
    .rst_n         (rst_n),
    .rdy_in        (rdy_in),
    .alloc         (rob_alloc),
    .alloc_rd      (rename_rd),
    .cdb_valid     (cdb_valid),
    .cdb_robid     (cdb_robid),
    .cdb_value     (cdb_value),
    .query_j       (query_j),
    .query_k       (query_k),
    .next_robid    (next_robid),
    .rob_next_full (rob_next_full),
    .rs1_ready     (rob_rs1_ready),
    .rs2_ready     (rob_rs2_ready),
    .rs1_value     (rob_rs1_value),
    .rs2_value     (rob_rs2_value),
    .commit        (cmt.src)
  );

  reservation_station u_reservation_station (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .rdy_in       (rdy_in),
    .cdb_valid    (cdb_valid),
    .cdb_robid    (cdb_robid),
    .cdb_value    (cdb_value),
    .alu_valid    (alu_valid),
    .alu_op       (alu_op),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .alu_robid    (alu_robid),
    .rs_next_full (rs_next_full),
    .dispatch     (disp.dst)
  );

  alu u_alu (
    .valid     (alu_valid),
    .op        (alu_op),
    .a         (alu_a),
    .b         (alu_b),
    .robid     (alu_robid),
    .cdb_valid (cdb_valid),
    .cdb_robid (cdb_robid),
    .cdb_value (cdb_value)
  );

endmodule

// ==== tb_ooo_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// core testbench with lfsr stimulus,
// reference model, commit checks and report
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ooo_core;
  import ooo_pkg::*;

  // 16 + 20 + 40 + 8 + 200 instructions
  localparam int TOTAL_INST  = 284;
  localparam int CYCLE_LIMIT = 10 * TOTAL_INST + 200;
  localparam int NUM_OPS     = 13;

  logic                clk_in;
  logic                rst_n;
  logic                rdy_in;
  logic                inst_valid;
  logic [XLEN-1:0]     inst;
  logic                inst_stall;
  logic                commit_valid;
  logic [REG_ID_W-1:0] commit_rd;
  logic [XLEN-1:0]     commit_value;

  // reference model state
  logic [XLEN-1:0]     arch [32];
  logic [REG_ID_W-1:0] exp_rd_q [$];
  logic [XLEN-1:0]     exp_val_q [$];

  logic [31:0] lfsr_state = 32'hf5c8fe40;
  int          cycle_cnt  = 0;
  int          err_cnt    = 0;
  int          err_start  = 0;
  int          test_cnt   = 0;
  int          fail_tests = 0;
  int          acc_cnt    = 0;
  int          commit_cnt = 0;
  logic        stall_seen = 1'b0;
  string       cur_test   = "none";

  ooo_core u_ooo_core (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .rdy_in       (rdy_in),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_stall   (inst_stall),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_value (commit_value)
  );

  initial clk_in = 1'b0;
  always #2 clk_in = ~clk_in;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // sel 0..7 register forms and 8..12 immediate forms
  function automatic logic [31:0] encode(input int sel, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
    inst_u w;
    logic [2:0] f3;
    w = '0;
    case (sel)
      0, 1, 8: f3 = FUNCT3_ADD;
      2, 9:    f3 = FUNCT3_AND;
      3, 10:   f3 = FUNCT3_OR;
      4, 11:   f3 = FUNCT3_XOR;
      5, 12:   f3 = FUNCT3_SLT;
      6:       f3 = FUNCT3_SLL;
      default: f3 = FUNCT3_SRL;
    endcase
    if (sel < 8) begin
      w.r.opcode = OPC_OP;
      w.r.funct7 = (sel == 1) ? FUNCT7_ALT : 7'b0;
      w.r.rs2    = rs2;
      w.r.rs1    = rs1;
      w.r.funct3 = f3;
      w.r.rd     = rd;
    end else begin
      w.i.opcode = OPC_OP_IMM;
      w.i.imm12  = imm;
      w.i.rs1    = rs1;
      w.i.funct3 = f3;
      w.i.rd     = rd;
    end
    return w;
  endfunction

  // rv32i semantics of the chosen operation
  function automatic logic [31:0] ref_exec(input int sel, input logic [31:0] a,
                                           input logic [31:0] rb, input logic [11:0] imm);
    logic [31:0] b;
    b = (sel >= 8) ? {{20{imm[11]}}, imm} : rb;
    case (sel)
      0, 8:    return a + b;
      1:       return a - b;
      2, 9:    return a & b;
      3, 10:   return a | b;
      4, 11:   return a ^ b;
      5, 12:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      6:       return a << b[4:0];
      default: return a >> b[4:0];
    endcase
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic send_inst(input int sel, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [11:0] imm);
    logic [31:0] res;
    inst       = encode(sel, rd, rs1, rs2, imm);
    inst_valid = 1'b1;
    @(negedge clk_in);
    // hold the word until the core takes it
    while (inst_stall || !rdy_in)
      @(negedge clk_in);
    @(posedge clk_in);
    #1;
    inst_valid = 1'b0;
    res = ref_exec(sel, arch[rs1], arch[rs2], imm);
    if (rd != 5'd0)
      arch[rd] = res;
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(res);
    acc_cnt++;
  endtask

  // bounded wait for every expected commit
  task automatic wait_drain();
    int limit;
    int n;
    limit = 10 * exp_rd_q.size() + 20;
    n     = 0;
    while (exp_rd_q.size() != 0 && n < limit) begin
      @(posedge clk_in);
      n++;
    end
    // margin to catch a stray extra commit
    repeat (2) @(posedge clk_in);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test   = name;
    err_start  = err_cnt;
    acc_cnt    = 0;
    commit_cnt = 0;
    stall_seen = 1'b0;
  endtask

  task automatic end_test();
    test_cnt++;
    if (err_cnt != err_start)
      fail_tests++;
    $display("test %s: %0d accepted, %0d committed, %0d errors",
             cur_test, acc_cnt, commit_cnt, err_cnt - err_start);
  endtask

  // outputs sampled mid-cycle between drive and capture
  always @(negedge clk_in) begin : commit_check
    logic [4:0]  exp_rd;
    logic [31:0] exp_val;
    if (rst_n) begin
      if (inst_stall)
        stall_seen = 1'b1;
      if (!rdy_in) begin
        assert (!commit_valid) else begin
          $display("%s: commit_valid high while rdy_in is low", cur_test);
          err_cnt++;
        end
      end
      if (commit_valid) begin
        commit_cnt++;
        assert (exp_rd_q.size() != 0) else begin
          $display("%s: commit seen with no instruction outstanding", cur_test);
          err_cnt++;
        end
        if (exp_rd_q.size() != 0) begin
          exp_rd  = exp_rd_q.pop_front();
          exp_val = exp_val_q.pop_front();
          assert (commit_rd == exp_rd && commit_value == exp_val) else begin
            $display("MISMATCH %s: expected x%0d=%08h, actual x%0d=%08h",
                     cur_test, exp_rd, exp_val, commit_rd, commit_value);
            err_cnt++;
          end
        end
      end
    end
  end

  // run length guard
  always @(posedge clk_in) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin : stimulus
    logic [4:0] rd;
    logic [4:0] prev_rd;
    int         sel;
    rst_n      = 1'b0;
    rdy_in     = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    for (int i = 0; i < 32; i++)
      arch[i] = '0;
    repeat (3) @(posedge clk_in);
    #1;
    rst_n = 1'b1;

    // idle outputs after reset
    start_test("reset");
    repeat (4) begin
      @(negedge clk_in);
      assert (!commit_valid && !inst_stall) else begin
        $display("reset: commit_valid or inst_stall high while idle");
        err_cnt++;
      end
    end
    @(posedge clk_in);
    #1;
    end_test();

    // destinations x1..x16 reading only x0
    start_test("independent");
    for (int i = 0; i < 16; i++) begin
      sel = rand_bits(4) % NUM_OPS;
      send_inst(sel, 5'(i + 1), 5'd0, 5'd0, 12'(rand_bits(12)));
    end
    wait_drain();
    end_test();

    // each one reads the previous destination
    start_test("dependency_chain");
    prev_rd = 5'd1;
    for (int i = 0; i < 20; i++) begin
      sel = rand_bits(4) % NUM_OPS;
      rd  = 5'(rand_bits(5) % 31 + 1);
      send_inst(sel, rd, prev_rd, 5'(rand_bits(5)), 12'(rand_bits(12)));
      prev_rd = rd;
    end
    wait_drain();
    end_test();

    // dependent burst fills the rs and forces a stall
    start_test("back_pressure");
    for (int i = 0; i < 40; i++) begin
      sel = rand_bits(4) % NUM_OPS;
      rd  = 5'(rand_bits(5) % 31 + 1);
      send_inst(sel, rd, prev_rd, prev_rd, 12'(rand_bits(12)));
      prev_rd = rd;
    end
    wait_drain();
    assert (stall_seen) else begin
      $display("back_pressure: inst_stall never went high during the burst");
      err_cnt++;
    end
    assert (commit_cnt == acc_cnt) else begin
      $display("back_pressure: %0d commits for %0d accepted", commit_cnt, acc_cnt);
      err_cnt++;
    end
    end_test();

    // pause with work still in flight
    start_test("pause");
    for (int i = 0; i < 8; i++) begin
      sel = rand_bits(4) % NUM_OPS;
      rd  = 5'(rand_bits(5) % 31 + 1);
      send_inst(sel, rd, prev_rd, 5'(rand_bits(5)), 12'(rand_bits(12)));
      prev_rd = rd;
    end
    rdy_in = 1'b0;
    repeat (10) @(posedge clk_in);
    #1;
    rdy_in = 1'b1;
    wait_drain();
    end_test();

    start_test("random_mix");
    for (int i = 0; i < 200; i++) begin
      sel = rand_bits(4) % NUM_OPS;
      send_inst(sel, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)),
                12'(rand_bits(12)));
    end
    wait_drain();
    assert (exp_rd_q.size() == 0) else begin
      $display("random_mix: %0d results never committed", exp_rd_q.size());
      err_cnt++;
    end
    end_test();

    $display("summary: %0d tests, %0d failed, %0d errors", test_cnt, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== ooo_core.f ====
ooo_pkg.sv
core_ifs.sv
alu.sv
reg_file.sv
reorder_buffer.sv
reservation_station.sv
issue_unit.sv
ooo_core.sv
tb_ooo_core.sv
